// ==== include/bus_params.svh ====
`ifndef BUS_PARAMS_SVH
`define BUS_PARAMS_SVH

// word and field widths
`define BUS_DATA_W       16
`define BUS_ADDR_W       12
`define BUS_SID_W        2

`define BUS_N_MASTERS    2
`define BUS_N_SLAVES     3

// per-slave memory depth in words, slave ids run from 1
`define BUS_DEPTH_S1     4096
`define BUS_DEPTH_S2     4096
`define BUS_DEPTH_S3     2048

`define BUS_FRAME_LEN    15  // sid, rd/wr, address
`define BUS_START_DELAY  20  // cycles between the two start pulses
`define BUS_FIRST_MASTER 0

`endif

// ==== verilog/bus_pkg.sv ====
`include "bus_params.svh"

package bus_pkg;

    typedef logic [`BUS_DATA_W-1:0] data_t;
    typedef logic [`BUS_ADDR_W-1:0] addr_t;
    typedef logic [`BUS_SID_W-1:0]  sid_t;
    typedef logic [$clog2(`BUS_DATA_W+1)-1:0] bit_cnt_t;  // counts serial bits

    // serial lines from the granted master to all slaves
    typedef struct packed {
        logic ctrl;   // control frame bit
        logic wd;     // write data bit
        logic valid;
        logic last;
    } m2s_t;

    // serial return lines from the slaves
    typedef struct packed {
        logic rd;
        logic rvalid;
    } s2m_t;

    typedef enum logic [2:0] {M_IDLE, M_REQ, M_FRAME, M_WDATA, M_RDATA, M_DONE} master_state_t;

    typedef enum logic [2:0] {S_IDLE, S_FRAME, S_WDATA, S_RDATA, S_SKIP} slave_state_t;

endpackage

// ==== verilog/ctrl_pkg.sv ====
`include "bus_params.svh"

package ctrl_pkg;

    import bus_pkg::*;

    // one command per master and session
    // sid 0 means the master does not touch the bus
    typedef struct packed {
        sid_t  sid;
        logic  wr;     // 1 for a write
        addr_t addr;
        data_t wdata;
    } master_cmd_t;

    typedef enum logic [1:0] {
        SES_IDLE,
        SES_FIRST,     // first master started, delay running
        SES_SECOND,    // both started, waiting for done
        SES_FINISHED
    } session_state_t;

endpackage

// ==== verilog/bus_master.sv ====
`timescale 1ns/1ps
`include "bus_params.svh"

module bus_master #(
    parameter int MASTER_IDX = 0
) (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  start,
    input  ctrl_pkg::master_cmd_t cmd,
    output logic                  req,
    input  logic                  gnt,
    output bus_pkg::m2s_t         m2s,
    input  bus_pkg::s2m_t         s2m,
    output logic                  done,
    output bus_pkg::data_t        rdata
);
    import bus_pkg::*;

    localparam int DW   = `BUS_DATA_W;
    localparam int SH_W = `BUS_FRAME_LEN + `BUS_DATA_W;
    localparam bit_cnt_t FRAME_LAST = bit_cnt_t'(`BUS_FRAME_LEN - 1);
    localparam bit_cnt_t DATA_LAST  = bit_cnt_t'(`BUS_DATA_W - 1);

    master_state_t   state;
    bit_cnt_t        cnt;
    logic [SH_W-1:0] tx_sh;  // frame in the low bits, write data above
    logic            wr_q;
    data_t           rx_sh;

    assign done = (state == M_DONE);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= M_IDLE;
            req   <= 1'b0;
            cnt   <= '0;
            rdata <= '0;
        end else begin
            case (state)
                M_IDLE: begin
                    if (start) begin
                        if (cmd.sid == '0) begin
                            state <= M_DONE;  // nothing to transfer
                        end else begin
                            req   <= 1'b1;
                            state <= M_REQ;
                        end
                    end
                end
                M_REQ: begin
                    if (gnt) begin
                        cnt   <= '0;
                        state <= M_FRAME;
                    end
                end
                M_FRAME: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == FRAME_LAST) begin
                        cnt   <= '0;
                        state <= wr_q ? M_WDATA : M_RDATA;
                    end
                end
                M_WDATA: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == DATA_LAST) state <= M_DONE;
                end
                M_RDATA: begin
                    if (s2m.rvalid) begin
                        cnt <= cnt + 1'b1;
                        if (cnt == DATA_LAST) begin
                            rdata <= {s2m.rd, rx_sh[DW-1:1]};  // word complete
                            state <= M_DONE;
                        end
                    end
                end
                M_DONE: begin
                    req   <= 1'b0;  // bus released after the done pulse
                    state <= M_IDLE;
                end
                default: state <= M_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == M_IDLE && start) begin
            tx_sh <= {cmd.wdata, cmd.addr, cmd.wr, cmd.sid};  // lsb goes out first
            wr_q  <= cmd.wr;
        end else if (state == M_FRAME || state == M_WDATA) begin
            tx_sh <= tx_sh >> 1;
        end
        if (state == M_RDATA && s2m.rvalid) rx_sh <= {s2m.rd, rx_sh[DW-1:1]};
    end

    always_comb begin
        m2s = '0;
        case (state)
            M_FRAME: begin
                m2s.ctrl  = tx_sh[0];
                m2s.valid = 1'b1;
                m2s.last  = (cnt == FRAME_LAST);
            end
            M_WDATA: begin
                m2s.wd    = tx_sh[0];
                m2s.valid = 1'b1;
                m2s.last  = (cnt == DATA_LAST);
            end
            default: ;
        endcase
    end

endmodule

// ==== verilog/bus_slave.sv ====
`timescale 1ns/1ps
`include "bus_params.svh"

module bus_slave #(
    parameter int SLAVE_ID = 1,
    parameter int DEPTH    = 4096
) (
    input  logic          clk,
    input  logic          rstN,
    input  bus_pkg::m2s_t m2s,
    output bus_pkg::s2m_t s2m
);
    import bus_pkg::*;

    localparam int AW = $clog2(DEPTH);  // upper address bits ignored, so the memory wraps
    localparam int FL = `BUS_FRAME_LEN;
    localparam int DW = `BUS_DATA_W;
    localparam int SW = `BUS_SID_W;
    localparam bit_cnt_t DATA_LAST = bit_cnt_t'(`BUS_DATA_W - 1);

    slave_state_t  state;
    bit_cnt_t      cnt;
    logic [FL-1:0] frame_sh;
    logic [FL-1:0] frame_now;  // frame including the bit on the line
    sid_t          frame_sid;
    logic          frame_wr;
    addr_t         rd_addr;
    addr_t         wr_addr;
    data_t         wr_sh;
    data_t         rd_sh;
    data_t         mem [DEPTH];

    assign frame_now = {m2s.ctrl, frame_sh[FL-1:1]};
    assign frame_sid = frame_now[SW-1:0];
    assign frame_wr  = frame_now[SW];
    assign rd_addr   = frame_now[FL-1 -: `BUS_ADDR_W];
    assign wr_addr   = frame_sh[FL-1 -: `BUS_ADDR_W];  // frame held during write data

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= S_IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                S_IDLE: if (m2s.valid) state <= S_FRAME;
                S_FRAME: begin
                    if (m2s.valid && m2s.last) begin
                        if (frame_sid != sid_t'(SLAVE_ID)) begin
                            state <= S_SKIP;
                        end else if (frame_wr) begin
                            state <= S_WDATA;
                        end else begin
                            cnt   <= '0;
                            state <= S_RDATA;
                        end
                    end
                end
                S_WDATA: if (m2s.valid && m2s.last) state <= S_IDLE;
                S_RDATA: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == DATA_LAST) state <= S_IDLE;
                end
                // another slave's transfer, wait for the lines to go quiet
                S_SKIP: if (!m2s.valid && !m2s.last) state <= S_IDLE;
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state == S_IDLE || state == S_FRAME) && m2s.valid) frame_sh <= frame_now;
        if (state == S_WDATA && m2s.valid) begin
            wr_sh <= {m2s.wd, wr_sh[DW-1:1]};
            if (m2s.last) mem[wr_addr[AW-1:0]] <= {m2s.wd, wr_sh[DW-1:1]};
        end
        if (state == S_FRAME && m2s.valid && m2s.last) begin
            rd_sh <= mem[rd_addr[AW-1:0]];  // first bit goes out next cycle
        end else if (state == S_RDATA) begin
            rd_sh <= rd_sh >> 1;
        end
    end

    always_comb begin
        s2m.rd     = (state == S_RDATA) & rd_sh[0];
        s2m.rvalid = (state == S_RDATA);
    end

endmodule

// ==== verilog/bus_arbiter.sv ====
`timescale 1ns/1ps
`include "bus_params.svh"

module bus_arbiter (
    input  logic                      clk,
    input  logic                      rstN,
    input  logic [`BUS_N_MASTERS-1:0] req,
    output logic [`BUS_N_MASTERS-1:0] gnt,
    input  bus_pkg::m2s_t             m2s_m [`BUS_N_MASTERS],
    output bus_pkg::m2s_t             m2s_bus,
    input  bus_pkg::s2m_t             s2m_s [`BUS_N_SLAVES],
    output bus_pkg::s2m_t             s2m_bus
);
    localparam int NM = `BUS_N_MASTERS;
    localparam int NS = `BUS_N_SLAVES;

    logic [NM-1:0] pick;

    // lowest set bit of req, master 0 has the highest priority
    assign pick = req & (~req + 1'b1);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            gnt <= '0;
        end else if (gnt == '0) begin
            gnt <= pick;
        end else if ((gnt & req) == '0) begin
            gnt <= '0;  // owner dropped req, bus free next cycle
        end
    end

    // steer the owner's lines, all zero while idle
    always_comb begin
        m2s_bus = '0;
        for (int i = 0; i < NM; i++) begin
            if (gnt[i]) m2s_bus = m2s_m[i];
        end
    end

    // only the addressed slave drives, so an OR is enough
    always_comb begin
        s2m_bus = '0;
        for (int i = 0; i < NS; i++) begin
            s2m_bus = s2m_bus | s2m_s[i];
        end
    end

endmodule

// ==== verilog/session_ctrl.sv ====
`timescale 1ns/1ps
`include "bus_params.svh"

module session_ctrl (
    input  logic                      clk,
    input  logic                      rstN,
    input  logic                      go,
    input  logic [`BUS_N_MASTERS-1:0] done_m,
    output logic [`BUS_N_MASTERS-1:0] start_m,
    output logic                      session_done
);
    import ctrl_pkg::*;

    localparam int N     = `BUS_N_MASTERS;
    localparam int CNT_W = $clog2(`BUS_START_DELAY + 1);
    localparam logic [N-1:0]     FIRST_SEL  = N'(1) << `BUS_FIRST_MASTER;
    localparam logic [N-1:0]     SECOND_SEL = ~FIRST_SEL;
    localparam logic [CNT_W-1:0] DELAY_LAST = CNT_W'(`BUS_START_DELAY - 1);

    session_state_t   state;
    logic [CNT_W-1:0] delay_cnt;
    logic [N-1:0]     seen;
    logic [N-1:0]     seen_next;

    assign seen_next = seen | done_m;  // sid 0 masters pulse done too

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state        <= SES_IDLE;
            delay_cnt    <= '0;
            seen         <= '0;
            start_m      <= '0;
            session_done <= 1'b0;
        end else begin
            start_m <= '0;  // start is a single-cycle pulse
            case (state)
                SES_IDLE, SES_FINISHED: begin
                    if (go) begin
                        start_m      <= FIRST_SEL;
                        delay_cnt    <= '0;
                        seen         <= '0;
                        session_done <= 1'b0;
                        state        <= SES_FIRST;
                    end
                end
                SES_FIRST: begin
                    seen      <= seen_next;
                    delay_cnt <= delay_cnt + 1'b1;
                    if (delay_cnt == DELAY_LAST) begin
                        start_m <= SECOND_SEL;
                        state   <= SES_SECOND;
                    end
                end
                SES_SECOND: begin
                    seen <= seen_next;
                    if (&seen_next) begin
                        session_done <= 1'b1;  // held until the next go
                        state        <= SES_FINISHED;
                    end
                end
                default: state <= SES_IDLE;
            endcase
        end
    end

endmodule

// ==== verilog/bus_system.sv ====
`timescale 1ns/1ps
`include "bus_params.svh"

module bus_system (
    input  logic                      clk,
    input  logic                      rstN,
    input  logic                      go,
    input  ctrl_pkg::master_cmd_t     cmd [`BUS_N_MASTERS],
    output logic [`BUS_N_MASTERS-1:0] done,
    output bus_pkg::data_t            rdata [`BUS_N_MASTERS],
    output logic                      session_done
);
    import bus_pkg::*;

    localparam int NM = `BUS_N_MASTERS;
    localparam int NS = `BUS_N_SLAVES;
    localparam int SLAVE_DEPTH [NS] = '{`BUS_DEPTH_S1, `BUS_DEPTH_S2, `BUS_DEPTH_S3};

    logic [NM-1:0] start;
    logic [NM-1:0] req;
    logic [NM-1:0] gnt;
    m2s_t          m2s_m [NM];
    m2s_t          m2s_bus;
    s2m_t          s2m_s [NS];
    s2m_t          s2m_bus;

    session_ctrl u_session_ctrl (
        .clk          (clk),
        .rstN         (rstN),
        .go           (go),
        .done_m       (done),
        .start_m      (start),
        .session_done (session_done)
    );

    for (genvar i = 0; i < NM; i++) begin : g_master
        bus_master #(.MASTER_IDX(i)) u_bus_master (
            .clk   (clk),
            .rstN  (rstN),
            .start (start[i]),
            .cmd   (cmd[i]),
            .req   (req[i]),
            .gnt   (gnt[i]),
            .m2s   (m2s_m[i]),
            .s2m   (s2m_bus),
            .done  (done[i]),
            .rdata (rdata[i])
        );
    end

    bus_arbiter u_bus_arbiter (
        .clk     (clk),
        .rstN    (rstN),
        .req     (req),
        .gnt     (gnt),
        .m2s_m   (m2s_m),
        .m2s_bus (m2s_bus),
        .s2m_s   (s2m_s),
        .s2m_bus (s2m_bus)
    );

    // slave ids start at 1
    for (genvar j = 0; j < NS; j++) begin : g_slave
        bus_slave #(.SLAVE_ID(j + 1), .DEPTH(SLAVE_DEPTH[j])) u_bus_slave (
            .clk  (clk),
            .rstN (rstN),
            .m2s  (m2s_bus),
            .s2m  (s2m_s[j])
        );
    end

endmodule

// ==== test/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock #(
    parameter real PERIOD_NS = 8.0
) (
    output logic clk
);

    initial clk = 1'b0;

    always #(PERIOD_NS / 2.0) clk = ~clk;  // free running, never stops on its own

endmodule

// ==== test/bus_system_assertions.sv ====
`timescale 1ns/1ps

module bus_system_assertions #(
    parameter int N        = 1,
    parameter bit HAS_DONE = 1
) (
    input logic         clk,
    input logic         rstN,
    input logic [N-1:0] gnt,
    input logic [N-1:0] done,
    input logic [N-1:0] valid
);

    // at most one owner of the shared serial lines, only seen where all grants meet
    if (N > 1) begin : g_grant
        grant_onehot: assert property (@(posedge clk) disable iff (!rstN) $onehot0(gnt))
            else $error("more than one master granted at once: %b", gnt);
    end

    // done is a single-cycle pulse
    if (HAS_DONE) begin : g_done
        done_single: assert property (@(posedge clk) disable iff (!rstN)
            (done & $past(done)) == '0)
            else $error("done stayed high for two cycles in a row");
    end

    valid_owner: assert property (@(posedge clk) disable iff (!rstN)
        (valid & ~gnt) == '0)  // a master only talks on the bus it owns
        else $error("valid driven by a master without a grant: valid %b gnt %b", valid, gnt);

endmodule

// ==== test/bus_system_tb.sv ====
`timescale 1ns/1ps
`include "bus_params.svh"

module bus_system_tb;
    import bus_pkg::*;
    import ctrl_pkg::*;

    localparam int NM           = `BUS_N_MASTERS;
    localparam int DRIVE_DELAY  = 1;
    localparam int N_SESSIONS   = 8;
    localparam int SESSION_MAX  = 200;  // worst case of one session with contention
    localparam int MAX_CYCLES   = N_SESSIONS * SESSION_MAX + 400;

    logic          clk;
    logic          rstN;
    logic          go;
    master_cmd_t   cmd [NM];
    logic [NM-1:0] done;
    data_t         rdata [NM];
    logic          session_done;

    data_t         ref_mem [`BUS_N_SLAVES][`BUS_DEPTH_S1];  // one row per slave
    data_t         exp_rdata [NM];
    logic [NM-1:0] exp_read = '0;
    logic [NM-1:0] done_seen = '0;
    logic          sd_prev = 1'b0;
    logic          go_prev = 1'b0;
    logic          bus_idle_expected = 1'b0;
    logic [31:0]   rng = 32'hbd0b6565;
    int unsigned   cycles = 0;

    tb_clock u_tb_clock (.clk(clk));

    bus_system u_bus_system (
        .clk          (clk),
        .rstN         (rstN),
        .go           (go),
        .cmd          (cmd),
        .done         (done),
        .rdata        (rdata),
        .session_done (session_done)
    );

    bind bus_arbiter bus_system_assertions #(.N(`BUS_N_MASTERS), .HAS_DONE(1'b0)) u_arbiter_checks (
        .clk   (clk),
        .rstN  (rstN),
        .gnt   (gnt),
        .done  ('0),  // done lives in the masters
        .valid ({m2s_m[1].valid, m2s_m[0].valid})
    );

    bind bus_master bus_system_assertions #(.N(1)) u_master_checks (
        .clk   (clk),
        .rstN  (rstN),
        .gnt   (gnt),
        .done  (done),
        .valid (m2s.valid)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic draw(output logic [31:0] r);
        rng = xorshift32(rng);
        r = rng;
    endtask

    // each slave keeps only as many address bits as its depth needs
    function automatic addr_t wrap_addr(input sid_t sid, input addr_t addr);
        int depth;
        case (sid)
            2'd1:    depth = `BUS_DEPTH_S1;
            2'd2:    depth = `BUS_DEPTH_S2;
            default: depth = `BUS_DEPTH_S3;
        endcase
        return addr_t'(int'(addr) % depth);
    endfunction

    function automatic master_cmd_t make_cmd(input sid_t sid, input logic wr, input addr_t addr,
                                             input data_t wdata);
        master_cmd_t c;
        c.sid   = sid;
        c.wr    = wr;
        c.addr  = addr;
        c.wdata = wdata;
        return c;
    endfunction

    task automatic stop_on_error(input string msg);
        $display("error at %0t ns: %s", $time, msg);
        $display("Simulation failed");
        $fatal(1, "check failed");
    endtask

    // update the model, set up expected reads, then run one go to session_done
    task automatic run_session(input master_cmd_t c0, input master_cmd_t c1);
        master_cmd_t c [NM];
        c[0] = c0;
        c[1] = c1;
        bus_idle_expected = (c0.sid == '0) && (c1.sid == '0);
        for (int m = 0; m < NM; m++) begin
            exp_read[m] = 1'b0;
            if (c[m].sid != '0) begin
                if (c[m].wr) begin
                    ref_mem[c[m].sid - 2'd1][wrap_addr(c[m].sid, c[m].addr)] = c[m].wdata;
                end else begin
                    exp_read[m]  = 1'b1;
                    exp_rdata[m] = ref_mem[c[m].sid - 2'd1][wrap_addr(c[m].sid, c[m].addr)];
                end
            end
        end
        cmd = c;
        go  = 1'b1;
        @(posedge clk);
        #DRIVE_DELAY;
        go = 1'b0;
        while (!session_done) begin
            @(posedge clk);
            #DRIVE_DELAY;
        end
        // quiet gap, session_done has to hold until the next go
        repeat (4) begin
            @(posedge clk);
            #DRIVE_DELAY;
        end
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == MAX_CYCLES) begin
            $display("timeout: the sessions did not finish within %0d cycles", MAX_CYCLES);
            $display("Simulation failed");
            $fatal(1, "timeout");
        end
    end

    // outputs settle well before the falling edge
    always @(negedge clk) begin
        if (rstN) begin
            for (int m = 0; m < NM; m++) begin
                if (done[m] && exp_read[m]) begin
                    assert (rdata[m] === exp_rdata[m])
                        else stop_on_error($sformatf("master %0d read %h, expected %h",
                                                     m, rdata[m], exp_rdata[m]));
                end
            end
            assert (!session_done || &done_seen)
                else stop_on_error("session_done high before both masters pulsed done");
            assert (!sd_prev || session_done || go_prev)
                else stop_on_error("session_done fell without a go");
            assert (!bus_idle_expected || u_bus_system.req == '0)
                else stop_on_error("bus requested in a session with both slave ids 0");
            done_seen = go ? '0 : (done_seen | done);
            sd_prev   = session_done;
            go_prev   = go;
        end
    end

    initial begin
        logic [31:0] r0;
        logic [31:0] r1;
        addr_t       a0;
        addr_t       a1;
        addr_t       b0;
        addr_t       b1;
        addr_t       c0;
        rstN = 1'b0;
        go   = 1'b0;
        for (int m = 0; m < NM; m++) cmd[m] = '0;
        repeat (4) @(posedge clk);
        #DRIVE_DELAY rstN = 1'b1;
        assert (done == '0 && !session_done && rdata[0] == '0 && rdata[1] == '0)
            else stop_on_error("outputs not cleared after reset");

        // master 0 on slave 1, master 1 on slave 3 above its depth
        draw(r0);
        draw(r1);
        a0 = r0[11:0];
        a1 = r1[11:0] | 12'h800;
        run_session(make_cmd(2'd1, 1'b1, a0, r0[31:16]), make_cmd(2'd3, 1'b1, a1, r1[31:16]));
        run_session(make_cmd(2'd1, 1'b0, a0, '0), make_cmd(2'd3, 1'b0, a1 & 12'h7ff, '0));

        draw(r0);
        draw(r1);
        b0 = r0[11:0];
        b1 = r1[11:0];
        run_session(make_cmd(2'd2, 1'b1, b0, r0[31:16]), make_cmd(2'd1, 1'b1, b1, r1[31:16]));
        run_session(make_cmd(2'd2, 1'b0, b0, '0), make_cmd(2'd1, 1'b0, b1, '0));

        // contention, both on slave 3, second master waits for the bus
        draw(r0);
        draw(r1);
        c0 = r0[11:0];
        run_session(make_cmd(2'd3, 1'b1, c0, r0[31:16]),
                    make_cmd(2'd3, 1'b1, c0 ^ 12'h001, r1[31:16]));
        run_session(make_cmd(2'd3, 1'b0, c0, '0), make_cmd(2'd3, 1'b0, c0 ^ 12'h001, '0));

        run_session(make_cmd(2'd0, 1'b0, '0, '0), make_cmd(2'd1, 1'b0, a0, '0));
        run_session(make_cmd(2'd0, 1'b1, '0, '0), make_cmd(2'd0, 1'b0, '0, '0));

        $display("Simulation passed");
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+include
verilog/bus_pkg.sv
verilog/ctrl_pkg.sv
verilog/bus_master.sv
verilog/bus_slave.sv
verilog/bus_arbiter.sv
verilog/session_ctrl.sv
verilog/bus_system.sv
test/tb_clock.sv
test/bus_system_assertions.sv
test/bus_system_tb.sv

// ==== Makefile ====
TOP := bus_system_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f flist.f --top-module $(TOP)

# a failed check ends in $fatal or $error, so the binary exits nonzero
sim:
	verilator --binary --timing --assert -f flist.f --top-module $(TOP) -o sim_$(TOP)
	./obj_dir/sim_$(TOP)

clean:
	rm -rf obj_dir
